//--- noc_bridge_pkg.sv
package noc_bridge_pkg;

    localparam int ADDR_W    = 16;
    localparam int DATA_W    = 32;
    localparam int ID_W      = 4;
    localparam int STRB_W    = 4;
    localparam int LEN_W     = 8;
    localparam int TDATA_W   = 40;
    localparam int COORD_W   = 2;
    localparam int MESH_COLS = 4;
    localparam int MESH_ROWS = 4;

    localparam int HDR_PAD_W = 24;  // bits above the packet count
    localparam int SUB_PAD_W = 7;   // bits above the subheader id
    localparam int W_PAD_W   = 8;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [ID_W-1:0]    id_t;
    typedef logic [STRB_W-1:0]  strb_t;
    typedef logic [LEN_W-1:0]   len_t;
    typedef logic [COORD_W-1:0] coord_t;
    typedef logic [TDATA_W-1:0] tdata_t;

    typedef enum logic [1:0] {
        ROUTING_HEADER = 2'd0,
        AW_SUBHEADER   = 2'd1,
        W_DATA         = 2'd2,
        AR_SUBHEADER   = 2'd3
    } pkt_kind_e;

    typedef struct packed {
        logic [HDR_PAD_W-1:0] pad;
        len_t                 pkt_count;
        coord_t               src_x;
        coord_t               src_y;
        coord_t               dst_x;
        coord_t               dst_y;      // lowest bits of the beat
    } routing_header_t;

    typedef struct packed {
        logic [SUB_PAD_W-1:0] pad;
        id_t                  id;
        addr_t                addr;
        len_t                 len;
        logic [2:0]           size;
        logic [1:0]           burst;
    } subheader_t;

    typedef struct packed {
        logic [W_PAD_W-1:0] pad;
        data_t              data;
    } w_beat_t;

endpackage

//--- noc_stream_if.sv
`timescale 1ns/1ns

interface noc_stream_if;
    import noc_bridge_pkg::*;

    logic      tvalid;
    logic      tready;
    pkt_kind_e tid;     // packet kind of the current beat
    tdata_t    tdata;
    strb_t     tstrb;
    logic      tlast;

    modport sender (
        output tvalid,
        input  tready,
        output tid,
        output tdata,
        output tstrb,
        output tlast
    );

    modport receiver (
        input  tvalid,
        output tready,
        input  tid,
        input  tdata,
        input  tstrb,
        input  tlast
    );

endinterface

//--- req_arbiter.sv
`timescale 1ns/1ns

module req_arbiter (
    input  logic ACLK,
    input  logic ARESETn,

    input  logic aw_pending_i,
    input  logic ar_pending_i,
    input  logic grant_done_i,

    output logic grant_valid_o,
    output logic grant_is_write_o
);

    logic grant_valid_q;
    logic grant_is_write_q;
    logic prio_write_q;
    logic pick_write;

    // a lone request wins, a tie goes to the kind the pointer favors
    assign pick_write = aw_pending_i && (!ar_pending_i || prio_write_q);

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            grant_valid_q    <= 1'b0;
            grant_is_write_q <= 1'b0;
            prio_write_q     <= 1'b1;
        end
        else if (!grant_valid_q) begin
            if (aw_pending_i || ar_pending_i) begin
                grant_valid_q    <= 1'b1;
                grant_is_write_q <= pick_write;
            end
        end
        else if (grant_done_i) begin
            grant_valid_q <= 1'b0;
            prio_write_q  <= !grant_is_write_q;  // other kind goes first next time
        end
    end

    assign grant_valid_o    = grant_valid_q;
    assign grant_is_write_o = grant_is_write_q;

endmodule

//--- req_packetizer.sv
`timescale 1ns/1ns

module req_packetizer #(
    parameter noc_bridge_pkg::coord_t ROUTER_X = '0,
    parameter noc_bridge_pkg::coord_t ROUTER_Y = '0
) (
    input  logic                  ACLK,
    input  logic                  ARESETn,

    input  noc_bridge_pkg::id_t   awid_i,
    input  noc_bridge_pkg::addr_t awaddr_i,
    input  noc_bridge_pkg::len_t  awlen_i,
    input  logic [2:0]            awsize_i,
    input  logic [1:0]            awburst_i,

    input  noc_bridge_pkg::id_t   arid_i,
    input  noc_bridge_pkg::addr_t araddr_i,
    input  noc_bridge_pkg::len_t  arlen_i,
    input  logic [2:0]            arsize_i,
    input  logic [1:0]            arburst_i,

    input  noc_bridge_pkg::data_t wdata_i,
    input  noc_bridge_pkg::strb_t wstrb_i,
    input  logic                  wlast_i,
    input  logic                  wvalid_i,

    output logic                  awready_o,
    output logic                  arready_o,
    output logic                  wready_o,

    input  logic                  grant_valid_i,
    input  logic                  grant_is_write_i,
    output logic                  grant_done_o,

    noc_stream_if.sender          stream_o
);
    import noc_bridge_pkg::*;

    typedef enum logic [1:0] {
        GEN_HEADER,
        AW_SEND,
        W_SEND,
        AR_SEND
    } state_e;

    state_e          state_q;
    state_e          state_d;
    id_t             dst_idx;
    routing_header_t header;
    subheader_t      aw_sub;
    subheader_t      ar_sub;
    w_beat_t         w_beat;

    always_comb begin
        dst_idx = (grant_is_write_i ? awid_i : arid_i) - id_t'(1);  // tiles are numbered from 1

        header           = '0;
        header.dst_y     = coord_t'((dst_idx / MESH_COLS) % MESH_ROWS);
        header.dst_x     = coord_t'(dst_idx % MESH_COLS);
        header.src_y     = ROUTER_Y;
        header.src_x     = ROUTER_X;
        header.pkt_count = grant_is_write_i ? len_t'(awlen_i + 8'd2) : len_t'(1);

        aw_sub       = '0;
        aw_sub.id    = awid_i;
        aw_sub.addr  = awaddr_i;
        aw_sub.len   = awlen_i;
        aw_sub.size  = awsize_i;
        aw_sub.burst = awburst_i;

        ar_sub       = '0;
        ar_sub.id    = arid_i;
        ar_sub.addr  = araddr_i;
        ar_sub.len   = arlen_i;
        ar_sub.size  = arsize_i;
        ar_sub.burst = arburst_i;

        w_beat      = '0;
        w_beat.data = wdata_i;
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q <= GEN_HEADER;
        end
        else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d         = state_q;
        stream_o.tvalid = 1'b0;
        stream_o.tid    = ROUTING_HEADER;
        stream_o.tdata  = tdata_t'(header);
        stream_o.tstrb  = '1;
        stream_o.tlast  = 1'b0;
        awready_o       = 1'b0;
        arready_o       = 1'b0;
        wready_o        = 1'b0;
        grant_done_o    = 1'b0;

        case (state_q)
            GEN_HEADER: begin
                stream_o.tvalid = grant_valid_i;
                if (grant_valid_i && stream_o.tready) begin
                    state_d = grant_is_write_i ? AW_SEND : AR_SEND;
                end
            end
            AW_SEND: begin
                stream_o.tvalid = 1'b1;
                stream_o.tid    = AW_SUBHEADER;
                stream_o.tdata  = tdata_t'(aw_sub);
                awready_o       = stream_o.tready;  // address accepted with the beat
                if (stream_o.tready) begin
                    state_d = W_SEND;
                end
            end
            W_SEND: begin
                stream_o.tvalid = wvalid_i;
                stream_o.tid    = W_DATA;
                stream_o.tdata  = tdata_t'(w_beat);
                stream_o.tstrb  = wstrb_i;
                stream_o.tlast  = wlast_i;
                wready_o        = stream_o.tready;
                if (wvalid_i && stream_o.tready && wlast_i) begin
                    grant_done_o = 1'b1;
                    state_d      = GEN_HEADER;
                end
            end
            AR_SEND: begin
                stream_o.tvalid = 1'b1;
                stream_o.tid    = AR_SUBHEADER;
                stream_o.tdata  = tdata_t'(ar_sub);
                stream_o.tlast  = 1'b1;  // a read packet ends on its subheader
                arready_o       = stream_o.tready;
                if (stream_o.tready) begin
                    grant_done_o = 1'b1;
                    state_d      = GEN_HEADER;
                end
            end
            default: begin
                state_d = GEN_HEADER;
            end
        endcase
    end

endmodule

//--- req_depacketizer.sv
`timescale 1ns/1ns

module req_depacketizer (
    noc_stream_if.receiver        stream_i,

    output logic                  m_awvalid_o,
    output noc_bridge_pkg::id_t   m_awid_o,
    output noc_bridge_pkg::addr_t m_awaddr_o,
    output noc_bridge_pkg::len_t  m_awlen_o,
    output logic [2:0]            m_awsize_o,
    output logic [1:0]            m_awburst_o,

    output logic                  m_arvalid_o,
    output noc_bridge_pkg::id_t   m_arid_o,
    output noc_bridge_pkg::addr_t m_araddr_o,
    output noc_bridge_pkg::len_t  m_arlen_o,
    output logic [2:0]            m_arsize_o,
    output logic [1:0]            m_arburst_o,

    output logic                  m_wvalid_o,
    output noc_bridge_pkg::data_t m_wdata_o,
    output noc_bridge_pkg::strb_t m_wstrb_o,
    output logic                  m_wlast_o,

    input  logic                  m_awready_i,
    input  logic                  m_arready_i,
    input  logic                  m_wready_i
);
    import noc_bridge_pkg::*;

    subheader_t sub;
    w_beat_t    w_beat;

    assign sub    = subheader_t'(stream_i.tdata);
    assign w_beat = w_beat_t'(stream_i.tdata);

    // payload fields follow the beat, only the valids depend on the kind
    assign m_awid_o    = sub.id;
    assign m_awaddr_o  = sub.addr;
    assign m_awlen_o   = sub.len;
    assign m_awsize_o  = sub.size;
    assign m_awburst_o = sub.burst;

    assign m_arid_o    = sub.id;
    assign m_araddr_o  = sub.addr;
    assign m_arlen_o   = sub.len;
    assign m_arsize_o  = sub.size;
    assign m_arburst_o = sub.burst;

    assign m_wdata_o = w_beat.data;
    assign m_wstrb_o = stream_i.tstrb;
    assign m_wlast_o = stream_i.tlast;

    always_comb begin
        m_awvalid_o     = 1'b0;
        m_arvalid_o     = 1'b0;
        m_wvalid_o      = 1'b0;
        stream_i.tready = 1'b1;

        case (stream_i.tid)
            ROUTING_HEADER: begin
                stream_i.tready = 1'b1;  // routing info is not needed past the router
            end
            AW_SUBHEADER: begin
                m_awvalid_o     = stream_i.tvalid;
                stream_i.tready = m_awready_i;
            end
            W_DATA: begin
                m_wvalid_o      = stream_i.tvalid;
                stream_i.tready = m_wready_i;
            end
            AR_SUBHEADER: begin
                m_arvalid_o     = stream_i.tvalid;
                stream_i.tready = m_arready_i;
            end
            default: begin
                stream_i.tready = 1'b1;
            end
        endcase
    end

endmodule

//--- noc_bridge_top.sv
`timescale 1ns/1ns

module noc_bridge_top #(
    parameter noc_bridge_pkg::coord_t ROUTER_X = '0,
    parameter noc_bridge_pkg::coord_t ROUTER_Y = '0
) (
    input  logic                      ACLK,
    input  logic                      ARESETn,

    input  logic                      s_axi_awvalid_i,
    output logic                      s_axi_awready_o,
    input  noc_bridge_pkg::id_t       s_axi_awid_i,
    input  noc_bridge_pkg::addr_t     s_axi_awaddr_i,
    input  noc_bridge_pkg::len_t      s_axi_awlen_i,
    input  logic [2:0]                s_axi_awsize_i,
    input  logic [1:0]                s_axi_awburst_i,

    input  logic                      s_axi_wvalid_i,
    output logic                      s_axi_wready_o,
    input  noc_bridge_pkg::data_t     s_axi_wdata_i,
    input  noc_bridge_pkg::strb_t     s_axi_wstrb_i,
    input  logic                      s_axi_wlast_i,

    input  logic                      s_axi_arvalid_i,
    output logic                      s_axi_arready_o,
    input  noc_bridge_pkg::id_t       s_axi_arid_i,
    input  noc_bridge_pkg::addr_t     s_axi_araddr_i,
    input  noc_bridge_pkg::len_t      s_axi_arlen_i,
    input  logic [2:0]                s_axi_arsize_i,
    input  logic [1:0]                s_axi_arburst_i,

    output logic                      m_axis_req_tvalid_o,
    input  logic                      m_axis_req_tready_i,
    output noc_bridge_pkg::pkt_kind_e m_axis_req_tid_o,
    output noc_bridge_pkg::tdata_t    m_axis_req_tdata_o,
    output noc_bridge_pkg::strb_t     m_axis_req_tstrb_o,
    output logic                      m_axis_req_tlast_o,

    input  logic                      s_axis_req_tvalid_i,
    output logic                      s_axis_req_tready_o,
    input  noc_bridge_pkg::pkt_kind_e s_axis_req_tid_i,
    input  noc_bridge_pkg::tdata_t    s_axis_req_tdata_i,
    input  noc_bridge_pkg::strb_t     s_axis_req_tstrb_i,
    input  logic                      s_axis_req_tlast_i,

    output logic                      m_axi_awvalid_o,
    input  logic                      m_axi_awready_i,
    output noc_bridge_pkg::id_t       m_axi_awid_o,
    output noc_bridge_pkg::addr_t     m_axi_awaddr_o,
    output noc_bridge_pkg::len_t      m_axi_awlen_o,
    output logic [2:0]                m_axi_awsize_o,
    output logic [1:0]                m_axi_awburst_o,

    output logic                      m_axi_wvalid_o,
    input  logic                      m_axi_wready_i,
    output noc_bridge_pkg::data_t     m_axi_wdata_o,
    output noc_bridge_pkg::strb_t     m_axi_wstrb_o,
    output logic                      m_axi_wlast_o,

    output logic                      m_axi_arvalid_o,
    input  logic                      m_axi_arready_i,
    output noc_bridge_pkg::id_t       m_axi_arid_o,
    output noc_bridge_pkg::addr_t     m_axi_araddr_o,
    output noc_bridge_pkg::len_t      m_axi_arlen_o,
    output logic [2:0]                m_axi_arsize_o,
    output logic [1:0]                m_axi_arburst_o
);

    noc_stream_if req_out_if ();
    noc_stream_if req_in_if ();

    logic grant_valid;
    logic grant_is_write;
    logic grant_done;

    assign m_axis_req_tvalid_o = req_out_if.tvalid;
    assign req_out_if.tready   = m_axis_req_tready_i;
    assign m_axis_req_tid_o    = req_out_if.tid;
    assign m_axis_req_tdata_o  = req_out_if.tdata;
    assign m_axis_req_tstrb_o  = req_out_if.tstrb;
    assign m_axis_req_tlast_o  = req_out_if.tlast;

    assign req_in_if.tvalid     = s_axis_req_tvalid_i;
    assign s_axis_req_tready_o  = req_in_if.tready;
    assign req_in_if.tid        = s_axis_req_tid_i;
    assign req_in_if.tdata      = s_axis_req_tdata_i;
    assign req_in_if.tstrb      = s_axis_req_tstrb_i;
    assign req_in_if.tlast      = s_axis_req_tlast_i;

    req_arbiter u_req_arbiter (
        .ACLK             (ACLK),
        .ARESETn          (ARESETn),
        .aw_pending_i     (s_axi_awvalid_i),
        .ar_pending_i     (s_axi_arvalid_i),
        .grant_done_i     (grant_done),
        .grant_valid_o    (grant_valid),
        .grant_is_write_o (grant_is_write)
    );

    req_packetizer #(
        .ROUTER_X (ROUTER_X),
        .ROUTER_Y (ROUTER_Y)
    ) u_req_packetizer (
        .ACLK             (ACLK),
        .ARESETn          (ARESETn),
        .awid_i           (s_axi_awid_i),
        .awaddr_i         (s_axi_awaddr_i),
        .awlen_i          (s_axi_awlen_i),
        .awsize_i         (s_axi_awsize_i),
        .awburst_i        (s_axi_awburst_i),
        .arid_i           (s_axi_arid_i),
        .araddr_i         (s_axi_araddr_i),
        .arlen_i          (s_axi_arlen_i),
        .arsize_i         (s_axi_arsize_i),
        .arburst_i        (s_axi_arburst_i),
        .wdata_i          (s_axi_wdata_i),
        .wstrb_i          (s_axi_wstrb_i),
        .wlast_i          (s_axi_wlast_i),
        .wvalid_i         (s_axi_wvalid_i),
        .awready_o        (s_axi_awready_o),
        .arready_o        (s_axi_arready_o),
        .wready_o         (s_axi_wready_o),
        .grant_valid_i    (grant_valid),
        .grant_is_write_i (grant_is_write),
        .grant_done_o     (grant_done),
        .stream_o         (req_out_if.sender)
    );

    req_depacketizer u_req_depacketizer (
        .stream_i    (req_in_if.receiver),
        .m_awvalid_o (m_axi_awvalid_o),
        .m_awid_o    (m_axi_awid_o),
        .m_awaddr_o  (m_axi_awaddr_o),
        .m_awlen_o   (m_axi_awlen_o),
        .m_awsize_o  (m_axi_awsize_o),
        .m_awburst_o (m_axi_awburst_o),
        .m_arvalid_o (m_axi_arvalid_o),
        .m_arid_o    (m_axi_arid_o),
        .m_araddr_o  (m_axi_araddr_o),
        .m_arlen_o   (m_axi_arlen_o),
        .m_arsize_o  (m_axi_arsize_o),
        .m_arburst_o (m_axi_arburst_o),
        .m_wvalid_o  (m_axi_wvalid_o),
        .m_wdata_o   (m_axi_wdata_o),
        .m_wstrb_o   (m_axi_wstrb_o),
        .m_wlast_o   (m_axi_wlast_o),
        .m_awready_i (m_axi_awready_i),
        .m_arready_i (m_axi_arready_i),
        .m_wready_i  (m_axi_wready_i)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;  // 4 ns period
    end

endmodule

//--- noc_bridge_tb.sv
`timescale 1ns/1ns

module noc_bridge_tb;
    import noc_bridge_pkg::*;

    localparam coord_t SRC_X       = 2'd1;
    localparam coord_t SRC_Y       = 2'd2;
    localparam int     N_OPS       = 12;  // write, pair, read, pair repeated
    localparam int     N_IN        = 8;
    localparam int     N_PKTS      = N_OPS * 3 / 2 + N_IN;
    localparam int     CYCLE_LIMIT = 200 * N_PKTS;

    typedef struct packed {
        pkt_kind_e tid;
        tdata_t    tdata;
        strb_t     tstrb;
        logic      tlast;
    } beat_t;

    logic       ACLK;
    logic       ARESETn;
    logic       s_axi_awvalid_i, s_axi_awready_o, s_axi_arvalid_i, s_axi_arready_o;
    id_t        s_axi_awid_i, s_axi_arid_i, m_axi_awid_o, m_axi_arid_o;
    addr_t      s_axi_awaddr_i, s_axi_araddr_i, m_axi_awaddr_o, m_axi_araddr_o;
    len_t       s_axi_awlen_i, s_axi_arlen_i, m_axi_awlen_o, m_axi_arlen_o;
    logic [2:0] s_axi_awsize_i, s_axi_arsize_i, m_axi_awsize_o, m_axi_arsize_o;
    logic [1:0] s_axi_awburst_i, s_axi_arburst_i, m_axi_awburst_o, m_axi_arburst_o;
    logic       s_axi_wvalid_i, s_axi_wready_o, s_axi_wlast_i;
    data_t      s_axi_wdata_i, m_axi_wdata_o;
    strb_t      s_axi_wstrb_i, m_axi_wstrb_o, m_axis_req_tstrb_o, s_axis_req_tstrb_i;
    logic       m_axis_req_tvalid_o, m_axis_req_tready_i, m_axis_req_tlast_o;
    logic       s_axis_req_tvalid_i, s_axis_req_tready_o, s_axis_req_tlast_i;
    pkt_kind_e  m_axis_req_tid_o, s_axis_req_tid_i;
    tdata_t     m_axis_req_tdata_o, s_axis_req_tdata_i;
    logic       m_axi_awvalid_o, m_axi_awready_i, m_axi_arvalid_o, m_axi_arready_i;
    logic       m_axi_wvalid_o, m_axi_wready_i, m_axi_wlast_o;

    int          seed = 7;
    int          err_beat = 0;
    int          err_proto = 0;
    int          err_axi = 0;
    int          cycles;
    logic        prio_write = 1'b1;  // the bridge favors writes after reset
    logic        do_write;
    logic        do_read;
    data_t       w_data [8];
    strb_t       w_strb [8];
    beat_t       exp_q [$];
    logic [38:0] exp_m [$];
    beat_t       got;

    tb_clock_gen u_clock_gen (.clk_o(ACLK));

    noc_bridge_top #(.ROUTER_X(SRC_X), .ROUTER_Y(SRC_Y)) dut (.*);

    function automatic tdata_t header_bits(input id_t id, input len_t count);
        id_t idx;
        idx = id - 4'd1;  // tile ids start at 1
        return {24'd0, count, SRC_X, SRC_Y, coord_t'(idx % MESH_COLS), coord_t'(idx / MESH_COLS)};
    endfunction

    function automatic tdata_t sub_bits(input id_t id, input addr_t addr, input len_t len,
                                        input logic [2:0] size, input logic [1:0] burst);
        return {7'd0, id, addr, len, size, burst};
    endfunction

    task automatic report_protocol(input string what);
        err_proto++;
        $display("[FAIL] %0t: %s", $time, what);
    endtask

    // returns on the falling edge after the handshake edge
    task automatic wait_ready(input int ch);
        #1;
        while (!(ch == 0 ? s_axi_awready_o : ch == 1 ? s_axi_wready_o :
                 ch == 2 ? s_axi_arready_o : s_axis_req_tready_o)) begin
            @(negedge ACLK);
            #1;
        end
        @(negedge ACLK);
    endtask

    task automatic prepare_write();
        s_axi_awid_i    = id_t'($random(seed));
        s_axi_awaddr_i  = addr_t'($random(seed));
        s_axi_awlen_i   = len_t'($random(seed) & 7);
        s_axi_awsize_i  = 3'd2;
        s_axi_awburst_i = 2'(($random(seed) & 1) + 1);
        for (int i = 0; i < 8; i++) begin
            w_data[i] = data_t'($random(seed));
            w_strb[i] = strb_t'($random(seed));
        end
    endtask

    task automatic prepare_read();
        s_axi_arid_i    = id_t'($random(seed));
        s_axi_araddr_i  = addr_t'($random(seed));
        s_axi_arlen_i   = len_t'($random(seed));
        s_axi_arsize_i  = 3'($random(seed));
        s_axi_arburst_i = 2'($random(seed));
    endtask

    task automatic expect_write();
        exp_q.push_back(beat_t'{ROUTING_HEADER,
                                header_bits(s_axi_awid_i, len_t'(s_axi_awlen_i + 8'd2)), '1, 1'b0});
        exp_q.push_back(beat_t'{AW_SUBHEADER, sub_bits(s_axi_awid_i, s_axi_awaddr_i,
                                s_axi_awlen_i, s_axi_awsize_i, s_axi_awburst_i), '1, 1'b0});
        for (int i = 0; i <= s_axi_awlen_i; i++) begin
            exp_q.push_back(beat_t'{W_DATA, {8'd0, w_data[i]}, w_strb[i], i == s_axi_awlen_i});
        end
    endtask

    task automatic expect_read();
        exp_q.push_back(beat_t'{ROUTING_HEADER, header_bits(s_axi_arid_i, 8'd1), '1, 1'b0});
        exp_q.push_back(beat_t'{AR_SUBHEADER, sub_bits(s_axi_arid_i, s_axi_araddr_i,
                                s_axi_arlen_i, s_axi_arsize_i, s_axi_arburst_i), '1, 1'b1});
    endtask

    task automatic drive_aw();
        s_axi_awvalid_i = 1'b1;
        wait_ready(0);
        s_axi_awvalid_i = 1'b0;
    endtask

    task automatic drive_w();
        for (int i = 0; i <= s_axi_awlen_i; i++) begin
            while (($random(seed) & 3) == 0) @(negedge ACLK);
            s_axi_wvalid_i = 1'b1;
            s_axi_wdata_i  = w_data[i];
            s_axi_wstrb_i  = w_strb[i];
            s_axi_wlast_i  = (i == s_axi_awlen_i);
            wait_ready(1);
            s_axi_wvalid_i = 1'b0;
        end
    endtask

    task automatic drive_ar();
        s_axi_arvalid_i = 1'b1;
        wait_ready(2);
        s_axi_arvalid_i = 1'b0;
    endtask

    task automatic send_beat(input pkt_kind_e kind, input tdata_t data, input strb_t strb,
                             input logic last);
        s_axis_req_tvalid_i = 1'b1;
        s_axis_req_tid_i    = kind;
        s_axis_req_tdata_i  = data;
        s_axis_req_tstrb_i  = strb;
        s_axis_req_tlast_i  = last;
        wait_ready(3);
        s_axis_req_tvalid_i = 1'b0;
    endtask

    task automatic inject_packet(input logic is_write);
        id_t        id;
        addr_t      addr;
        len_t       len;
        logic [2:0] size;
        logic [1:0] burst;
        data_t      data;
        strb_t      strb;
        id    = id_t'($random(seed));
        addr  = addr_t'($random(seed));
        len   = len_t'($random(seed) & 3);
        size  = 3'($random(seed));
        burst = 2'($random(seed));
        send_beat(ROUTING_HEADER, tdata_t'({$random(seed), $random(seed)}), '1, 1'b0);
        if (is_write) begin
            exp_m.push_back({AW_SUBHEADER, 4'd0, id, addr, len, size, burst});
            send_beat(AW_SUBHEADER, sub_bits(id, addr, len, size, burst), '1, 1'b0);
            for (int i = 0; i <= len; i++) begin
                data = data_t'($random(seed));
                strb = strb_t'($random(seed));
                exp_m.push_back({W_DATA, data, strb, i == len});
                send_beat(W_DATA, {8'd0, data}, strb, i == len);
            end
        end
        else begin
            exp_m.push_back({AR_SUBHEADER, 4'd0, id, addr, len, size, burst});
            send_beat(AR_SUBHEADER, sub_bits(id, addr, len, size, burst), '1, 1'b1);
        end
    endtask

    task automatic check_axi(input logic [38:0] seen);
        if (exp_m.size() == 0) begin
            err_axi++;
            $display("m_axi transfer at %0t without a matching s_axis beat", $time);
        end
        else begin
            assert (seen == exp_m[0]) else begin
                err_axi++;
                $display("[FAIL] %0t: m_axi transfer %h, expected %h", $time, seen, exp_m[0]);
            end
            void'(exp_m.pop_front());
        end
    endtask

    always @(negedge ACLK) begin
        m_axis_req_tready_i <= ($random(seed) & 3) != 0;
        m_axi_awready_i     <= ($random(seed) & 3) != 0;
        m_axi_wready_i      <= ($random(seed) & 3) != 0;
        m_axi_arready_i     <= ($random(seed) & 3) != 0;
    end

    always @(negedge ACLK) begin
        #1;
        if (m_axis_req_tvalid_o && m_axis_req_tready_i) begin
            got = beat_t'{m_axis_req_tid_o, m_axis_req_tdata_o, m_axis_req_tstrb_o,
                          m_axis_req_tlast_o};
            if (got.tid != W_DATA) got.tstrb = '1;  // strobes only mean something on W beats
            if (exp_q.size() == 0) begin
                err_beat++;
                $display("m_axis beat at %0t with no request outstanding", $time);
            end
            else begin
                assert (got == exp_q[0]) else begin
                    err_beat++;
                    $display("[FAIL] %0t: m_axis beat %h, expected %h", $time, got, exp_q[0]);
                end
                void'(exp_q.pop_front());
            end
        end
        if (m_axi_awvalid_o && m_axi_awready_i)
            check_axi({AW_SUBHEADER, 4'd0, m_axi_awid_o, m_axi_awaddr_o, m_axi_awlen_o,
                       m_axi_awsize_o, m_axi_awburst_o});
        if (m_axi_wvalid_o && m_axi_wready_i)
            check_axi({W_DATA, m_axi_wdata_o, m_axi_wstrb_o, m_axi_wlast_o});
        if (m_axi_arvalid_o && m_axi_arready_i)
            check_axi({AR_SUBHEADER, 4'd0, m_axi_arid_o, m_axi_araddr_o, m_axi_arlen_o,
                       m_axi_arsize_o, m_axi_arburst_o});
    end

    assert property (@(posedge ACLK) disable iff (!ARESETn)
        m_axis_req_tvalid_o && !m_axis_req_tready_i |=> m_axis_req_tvalid_o && $stable(
            {m_axis_req_tid_o, m_axis_req_tdata_o, m_axis_req_tstrb_o, m_axis_req_tlast_o}))
        else report_protocol("m_axis beat dropped or changed while stalled");
    assert property (@(posedge ACLK) disable iff (!ARESETn)
        !m_axis_req_tready_i |-> !(s_axi_awready_o || s_axi_arready_o || s_axi_wready_o))
        else report_protocol("s_axi ready high while m_axis is stalled");
    assert property (@(posedge ACLK) disable iff (!ARESETn)
        s_axi_awready_o == (m_axis_req_tvalid_o && m_axis_req_tready_i
                            && m_axis_req_tid_o == AW_SUBHEADER))
        else report_protocol("AWREADY not on the AW subheader transfer");
    assert property (@(posedge ACLK) disable iff (!ARESETn)
        s_axi_arready_o == (m_axis_req_tvalid_o && m_axis_req_tready_i
                            && m_axis_req_tid_o == AR_SUBHEADER))
        else report_protocol("ARREADY not on the AR subheader transfer");
    assert property (@(posedge ACLK) disable iff (!ARESETn)
        s_axis_req_tvalid_i && s_axis_req_tid_i == ROUTING_HEADER
            |-> !(m_axi_awvalid_o || m_axi_wvalid_o || m_axi_arvalid_o))
        else report_protocol("header beat caused m_axi activity");
    assert property (@(posedge ACLK) disable iff (!ARESETn)
        s_axis_req_tvalid_i && ((s_axis_req_tid_i == AW_SUBHEADER && !m_axi_awready_i)
            || (s_axis_req_tid_i == W_DATA && !m_axi_wready_i)
            || (s_axis_req_tid_i == AR_SUBHEADER && !m_axi_arready_i)) |-> !s_axis_req_tready_o)
        else report_protocol("s_axis accepted a beat while m_axi was stalled");

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge ACLK);
            cycles++;
        end
        $display("timeout after %0d cycles, some handshake never completed", CYCLE_LIMIT);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        ARESETn = 1'b0;
        {s_axi_awvalid_i, s_axi_wvalid_i, s_axi_arvalid_i, s_axi_wlast_i} = '0;
        {s_axi_awid_i, s_axi_awaddr_i, s_axi_awlen_i, s_axi_awsize_i, s_axi_awburst_i} = '0;
        {s_axi_arid_i, s_axi_araddr_i, s_axi_arlen_i, s_axi_arsize_i, s_axi_arburst_i} = '0;
        {s_axi_wdata_i, s_axi_wstrb_i} = '0;
        {s_axis_req_tvalid_i, s_axis_req_tdata_i, s_axis_req_tstrb_i, s_axis_req_tlast_i} = '0;
        s_axis_req_tid_i = ROUTING_HEADER;
        {m_axis_req_tready_i, m_axi_awready_i, m_axi_wready_i, m_axi_arready_i} = '0;
        repeat (3) @(posedge ACLK);
        @(negedge ACLK);
        ARESETn = 1'b1;

        fork
            begin
                for (int n = 0; n < N_OPS; n++) begin
                    do_write = (n % 4) != 2;
                    do_read  = (n % 4) != 0;
                    if (do_write) prepare_write();
                    if (do_read) prepare_read();
                    // on a tie the pointer picks, the other kind follows right after
                    if (do_write && (!do_read || prio_write)) begin
                        expect_write();
                        if (do_read) expect_read();
                    end
                    else begin
                        expect_read();
                        if (do_write) expect_write();
                    end
                    if (!(do_write && do_read)) prio_write = do_read;
                    fork
                        if (do_write) drive_aw();
                        if (do_write) drive_w();
                        if (do_read) drive_ar();
                    join
                end
            end
            begin
                for (int n = 0; n < N_IN; n++) begin
                    inject_packet(n % 2 == 0);
                end
            end
        join

        while (exp_q.size() + exp_m.size() != 0) @(negedge ACLK);
        repeat (4) @(negedge ACLK);
        $display("errors: m_axis beats %0d, protocol %0d, m_axi transfers %0d",
                 err_beat, err_proto, err_axi);
        if (err_beat + err_proto + err_axi == 0) begin
            $display("ALL TESTS PASSED");
        end
        else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- noc_bridge_top.f
noc_bridge_pkg.sv
noc_stream_if.sv
req_arbiter.sv
req_packetizer.sv
req_depacketizer.sv
noc_bridge_top.sv
tb_clock_gen.sv
noc_bridge_tb.sv
